// File: icache_cfg_pkg.sv
package icache_cfg_pkg;

    // ==============================
    // Cache geometry
    // ==============================

    // Processor side widths
    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;

    // One line holds four instruction words
    localparam int LINE_W      = 128;

    // Direct mapped, one line per index
    localparam int N_LINES     = 64;

    // Address split, low to high: byte, word offset, index, tag
    localparam int BYTE_BITS   = 2;
    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS  = 6;
    localparam int TAG_BITS    = 22;

    // ==============================
    // Address field types
    // ==============================

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [WORD_W-1:0]      word_t;

    // Word offset 0 lives in the top 32 bits of a line
    typedef logic [LINE_W-1:0]      line_t;

    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;

endpackage

// File: icache_ctrl_pkg.sv
package icache_ctrl_pkg;

    // ==============================
    // Controller encodings
    // ==============================

    // INIT covers the valid sweep after reset
    typedef enum logic [1:0] {
        INIT,
        IDLE,
        LOOKUP,
        REFILL
    } state_e;

    // Source of the word loaded into the response register
    typedef enum logic {
        SRC_CACHE,
        SRC_MEM
    } resp_src_e;

endpackage

// File: icache_if.sv
`timescale 1ns/100ps

interface icache_if;

    // Lookup address fields, driven by the controller
    icache_cfg_pkg::index_t      rd_index;
    icache_cfg_pkg::tag_t        lk_tag;
    icache_cfg_pkg::offset_t     lk_offset;

    // Refill write strobe for tag, valid and data line
    logic                        fill_we;

    // Response register load and its source
    logic                        capture;
    icache_ctrl_pkg::resp_src_e  capture_src;

    // Status back from the tag store
    logic                        hit;
    logic                        init_done;

    modport ctrl (
        output rd_index, lk_tag, lk_offset, fill_we, capture, capture_src,
        input  hit, init_done
    );

    modport tags (
        input  rd_index, lk_tag, fill_we,
        output hit, init_done
    );

    modport data (
        input  rd_index, lk_offset, fill_we, capture, capture_src
    );

endinterface

// File: icache_tag_store.sv
`timescale 1ns/100ps

module icache_tag_store (
    input  logic     clk_i,
    input  logic     rst_i,
    icache_if.tags   port
);

    // ==============================
    // Storage
    // ==============================

    // Distributed RAM style arrays, read asynchronously
    icache_cfg_pkg::tag_t    tag_mem   [icache_cfg_pkg::N_LINES];
    logic                    valid_mem [icache_cfg_pkg::N_LINES];

    // Sweep pointer and completion flag
    icache_cfg_pkg::index_t  init_cnt;
    logic                    init_done_q;

    // ==============================
    // Valid sweep after reset
    // ==============================

    // One line per cycle, last line sets init_done
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            init_cnt    <= '0;
            init_done_q <= 1'b0;
        end
        else if (!init_done_q)
        begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == icache_cfg_pkg::index_t'(icache_cfg_pkg::N_LINES - 1))
                init_done_q <= 1'b1;
        end
    end

    // Sweep clears valid, refill sets it
    // No refill can happen before the sweep ends
    always_ff @(posedge clk_i)
    begin
        if (!init_done_q)
            valid_mem[init_cnt] <= 1'b0;
        else if (port.fill_we)
            valid_mem[port.rd_index] <= 1'b1;
    end

    // Tag written together with the data line
    always_ff @(posedge clk_i)
    begin
        if (port.fill_we)
            tag_mem[port.rd_index] <= port.lk_tag;
    end

    // ==============================
    // Hit detection
    // ==============================

    // Same-cycle compare against the held lookup tag
    assign port.hit = valid_mem[port.rd_index]
                   && (tag_mem[port.rd_index] == port.lk_tag);

    assign port.init_done = init_done_q;

endmodule

// File: icache_data_store.sv
`timescale 1ns/100ps

module icache_data_store (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  icache_cfg_pkg::line_t   mem_line_i,
    output logic                    resp_valid_o,
    output icache_cfg_pkg::word_t   resp_data_o,
    icache_if.data                  port
);

    // ==============================
    // Line array
    // ==============================

    // Block RAM style, synchronous read port
    icache_cfg_pkg::line_t  line_mem [icache_cfg_pkg::N_LINES];
    icache_cfg_pkg::line_t  rd_line;

    // Selected line and the word picked out of it
    icache_cfg_pkg::line_t  src_line;
    icache_cfg_pkg::word_t  sel_word;

    // Offset 0 maps to the most significant word
    function automatic icache_cfg_pkg::word_t word_of(
        input icache_cfg_pkg::line_t   line,
        input icache_cfg_pkg::offset_t off
    );
        int unsigned top;
        top = icache_cfg_pkg::LINE_W - 1 - off * icache_cfg_pkg::WORD_W;
        return line[top -: icache_cfg_pkg::WORD_W];
    endfunction

    // Read at the accepting edge gives the line during LOOKUP
    always_ff @(posedge clk_i)
    begin
        if (port.fill_we)
            line_mem[port.rd_index] <= mem_line_i;
        rd_line <= line_mem[port.rd_index];
    end

    // ==============================
    // Word select
    // ==============================

    // Refill data bypasses the RAM on a miss
    assign src_line = (port.capture_src == icache_ctrl_pkg::SRC_MEM) ? mem_line_i : rd_line;
    assign sel_word = word_of(src_line, port.lk_offset);

    // ==============================
    // Response register
    // ==============================

    // Valid is a single-cycle pulse per capture
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            resp_valid_o <= 1'b0;
        else
            resp_valid_o <= port.capture;
    end

    // Data only moves on capture
    always_ff @(posedge clk_i)
    begin
        if (port.capture)
            resp_data_o <= sel_word;
    end

endmodule

// File: icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    input  icache_cfg_pkg::addr_t   req_addr_i,
    output logic                    req_ready_o,
    output logic                    mem_strobe_o,
    output icache_cfg_pkg::addr_t   mem_addr_o,
    input  logic                    mem_ready_i,
    icache_if.ctrl                  port
);

    // ==============================
    // State and request holding
    // ==============================

    icache_ctrl_pkg::state_e  state_q;
    icache_ctrl_pkg::state_e  state_d;

    // Fetch address held from acceptance until the response
    icache_cfg_pkg::addr_t    addr_q;

    // Index fields of the incoming and held addresses
    icache_cfg_pkg::index_t   req_index;
    icache_cfg_pkg::index_t   held_index;

    logic                     accept;

    // Ready only once the valid sweep is complete
    assign req_ready_o = (state_q == icache_ctrl_pkg::IDLE) && port.init_done;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= icache_ctrl_pkg::INIT;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk_i)
    begin
        if (accept)
            addr_q <= req_addr_i;
    end

    // ==============================
    // Next state
    // ==============================

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            icache_ctrl_pkg::INIT:
                if (port.init_done)
                    state_d = icache_ctrl_pkg::IDLE;
            icache_ctrl_pkg::IDLE:
                if (accept)
                    state_d = icache_ctrl_pkg::LOOKUP;
            // Hit returns at once, miss goes out to memory
            icache_ctrl_pkg::LOOKUP:
                state_d = port.hit ? icache_ctrl_pkg::IDLE : icache_ctrl_pkg::REFILL;
            icache_ctrl_pkg::REFILL:
                if (mem_ready_i)
                    state_d = icache_ctrl_pkg::IDLE;
            default:
                state_d = icache_ctrl_pkg::INIT;
        endcase
    end

    // ==============================
    // Lookup fields
    // ==============================

    assign req_index  = req_addr_i[icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFSET_BITS
                                   +: icache_cfg_pkg::INDEX_BITS];
    assign held_index = addr_q[icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFSET_BITS
                               +: icache_cfg_pkg::INDEX_BITS];

    // Incoming index at acceptance so the data RAM read lines up with LOOKUP
    assign port.rd_index  = accept ? req_index : held_index;
    assign port.lk_tag    = addr_q[icache_cfg_pkg::ADDR_W-1 -: icache_cfg_pkg::TAG_BITS];
    assign port.lk_offset = addr_q[icache_cfg_pkg::BYTE_BITS +: icache_cfg_pkg::OFFSET_BITS];

    // ==============================
    // Fill, capture and memory side
    // ==============================

    // Refill completes in the mem_ready_i cycle
    assign port.fill_we     = (state_q == icache_ctrl_pkg::REFILL) && mem_ready_i;
    assign port.capture     = ((state_q == icache_ctrl_pkg::LOOKUP) && port.hit)
                           || port.fill_we;
    assign port.capture_src = (state_q == icache_ctrl_pkg::REFILL)
                            ? icache_ctrl_pkg::SRC_MEM : icache_ctrl_pkg::SRC_CACHE;

    // Strobe held through the whole refill wait
    assign mem_strobe_o = (state_q == icache_ctrl_pkg::REFILL);

    // Line aligned, stable since addr_q only moves on acceptance
    assign mem_addr_o   = {port.lk_tag, held_index,
                           {(icache_cfg_pkg::OFFSET_BITS + icache_cfg_pkg::BYTE_BITS){1'b0}}};

endmodule

// File: icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Fetch request
    input  logic                    req_valid_i,
    input  icache_cfg_pkg::addr_t   req_addr_i,
    output logic                    req_ready_o,

    // Fetch response, never refused
    output logic                    resp_valid_o,
    output icache_cfg_pkg::word_t   resp_data_o,

    // Line refill port
    output logic                    mem_strobe_o,
    output icache_cfg_pkg::addr_t   mem_addr_o,
    input  logic                    mem_ready_i,
    input  icache_cfg_pkg::line_t   mem_line_i
);

    // ==============================
    // Internal bus
    // ==============================

    icache_if bus ();

    // Request FSM and memory request generation
    icache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_ready_o  (req_ready_o),
        .mem_strobe_o (mem_strobe_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ready_i  (mem_ready_i),
        .port         (bus.ctrl)
    );

    // Tags, valid bits and hit compare
    icache_tag_store u_tags (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .port  (bus.tags)
    );

    // Line data and the response register
    icache_data_store u_data (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_line_i   (mem_line_i),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .port         (bus.data)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset over the first 16 cycles, dropped after a falling edge
    initial
    begin
        rst_o = 1'b1;
        repeat (16) @(negedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: tb_icache.sv
`timescale 1ns/100ps

module tb_icache;

    logic                   clk_i;
    logic                   rst_i;
    logic                   req_valid_i;
    icache_cfg_pkg::addr_t  req_addr_i;
    logic                   req_ready_o;
    logic                   resp_valid_o;
    icache_cfg_pkg::word_t  resp_data_o;
    logic                   mem_strobe_o;
    icache_cfg_pkg::addr_t  mem_addr_o;
    logic                   mem_ready_i;
    icache_cfg_pkg::line_t  mem_line_i;

    // Expectations for the fetch in flight
    logic                   exp_hit;
    icache_cfg_pkg::word_t  exp_word;
    icache_cfg_pkg::addr_t  exp_line_addr;
    int unsigned            mem_delay;
    int unsigned            serve_cnt;
    logic                   sweep_over;
    logic                   accepted;

    // Reference copy of the tag store
    icache_cfg_pkg::tag_t   ref_tag   [icache_cfg_pkg::N_LINES];
    logic                   ref_valid [icache_cfg_pkg::N_LINES];

    tb_clock_gen clock_gen (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    icache_top uut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .mem_strobe_o (mem_strobe_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ready_i  (mem_ready_i),
        .mem_line_i   (mem_line_i)
    );

    task automatic show_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                 $time, sig, exp_val, act_val);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Memory content rule, word at byte address A is A xor C0DE0000
    function automatic icache_cfg_pkg::word_t model_word(input icache_cfg_pkg::addr_t addr);
        return (addr & 32'hFFFF_FFFC) ^ 32'hC0DE_0000;
    endfunction

    // Word 0 in the top bits of the line
    function automatic icache_cfg_pkg::line_t model_line(input icache_cfg_pkg::addr_t base);
        icache_cfg_pkg::line_t line;
        line = '0;
        for (int w = 0; w < icache_cfg_pkg::LINE_W / icache_cfg_pkg::WORD_W; w++)
            line[icache_cfg_pkg::LINE_W - 1 - w * icache_cfg_pkg::WORD_W -: icache_cfg_pkg::WORD_W]
                = model_word(base + 4 * w);
        return line;
    endfunction

    // ==============================
    // Checks
    // ==============================

    assign accepted = req_valid_i && req_ready_o;

    // Quiet until the sweep is over
    assert property (@(posedge clk_i) disable iff (rst_i)
        !sweep_over |-> !req_ready_o && !resp_valid_o && !mem_strobe_o)
        else show_error("cache became active during the valid sweep");

    // Hit answers two cycles after acceptance, no memory traffic
    assert property (@(posedge clk_i) disable iff (rst_i)
        accepted && exp_hit |-> ##2 (resp_valid_o && !mem_strobe_o))
        else show_error("hit response missing two cycles after acceptance");

    // Miss goes out to memory right after the lookup
    assert property (@(posedge clk_i) disable iff (rst_i)
        accepted && !exp_hit |-> ##2 mem_strobe_o)
        else show_error("miss raised no memory request");

    assert property (@(posedge clk_i) disable iff (rst_i)
        mem_strobe_o |-> mem_addr_o == exp_line_addr)
        else show_mismatch("mem_addr_o", exp_line_addr, mem_addr_o);

    assert property (@(posedge clk_i) disable iff (rst_i)
        mem_strobe_o ##1 mem_strobe_o |-> $stable(mem_addr_o))
        else show_error("mem_addr_o moved while mem_strobe_o waited");

    assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_o |-> resp_data_o == exp_word)
        else show_mismatch("resp_data_o", exp_word, resp_data_o);

    // ==============================
    // Memory model
    // ==============================

    // Ready for one cycle after the chosen delay
    always
    begin : memory_model
        @(negedge clk_i);
        mem_ready_i = 1'b0;
        if (mem_strobe_o)
        begin
            repeat (mem_delay - 1) @(negedge clk_i);
            mem_line_i  = model_line(mem_addr_o);
            mem_ready_i = 1'b1;
            serve_cnt   = serve_cnt + 1;
        end
    end

    // One fetch from drive to response, entered on a falling edge
    task automatic fetch(input icache_cfg_pkg::addr_t addr);
        int                      waited;
        icache_cfg_pkg::index_t  idx;
        icache_cfg_pkg::tag_t    tag;
        idx = addr[icache_cfg_pkg::BYTE_BITS + icache_cfg_pkg::OFFSET_BITS
                   +: icache_cfg_pkg::INDEX_BITS];
        tag = addr[icache_cfg_pkg::ADDR_W - 1 -: icache_cfg_pkg::TAG_BITS];
        exp_hit       = ref_valid[idx] && (ref_tag[idx] == tag);
        exp_word      = model_word(addr);
        // Offset and byte bits cleared
        exp_line_addr = addr & 32'hFFFF_FFF0;
        mem_delay     = $urandom_range(8, 1);
        serve_cnt     = 0;
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        waited = 0;
        while (!req_ready_o)
        begin
            @(negedge clk_i);
            waited++;
            if (waited > 16)
                show_error("request was never accepted");
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
        waited = 0;
        while (!resp_valid_o)
        begin
            @(negedge clk_i);
            waited++;
            if (waited > 32)
                show_error("no response to an accepted request");
        end
        // Let the response edge pass before the next fetch
        @(negedge clk_i);
        assert (serve_cnt == (exp_hit ? 0 : 1))
            else show_mismatch("memory request count", exp_hit ? 0 : 1, serve_cnt);
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin : stimulus
        int unsigned            seed_ret;
        int                     waited;
        icache_cfg_pkg::addr_t  addr;
        seed_ret      = $urandom(32'h6721e830);
        req_valid_i   = 1'b0;
        req_addr_i    = '0;
        mem_ready_i   = 1'b0;
        mem_line_i    = '0;
        sweep_over    = 1'b0;
        exp_hit       = 1'b0;
        exp_word      = '0;
        exp_line_addr = '0;
        mem_delay     = 1;
        serve_cnt     = 0;
        for (int i = 0; i < icache_cfg_pkg::N_LINES; i++)
        begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        @(negedge clk_i);
        waited = 0;
        while (rst_i)
        begin
            @(negedge clk_i);
            waited++;
            if (waited > 32)
                show_error("reset was never released");
        end
        // Sweep clears one line per cycle for N_LINES cycles
        repeat (icache_cfg_pkg::N_LINES) @(negedge clk_i);
        sweep_over = 1'b1;
        waited = 0;
        while (!req_ready_o)
        begin
            @(negedge clk_i);
            waited++;
            if (waited > 16)
                show_error("req_ready_o never rose after reset");
        end
        // Cold line, then each offset again from the cache
        fetch(32'h0000_0100);
        for (int off = 0; off < 4; off++)
            fetch(32'h0000_0100 + 4 * off);
        // Same index with another tag evicts the line
        fetch(32'h0000_0500);
        fetch(32'h0000_0104);
        // Random word addresses inside one 4 KB region
        for (int n = 0; n < 200; n++)
        begin
            addr = 32'h0004_0000 | ($urandom & 32'h0000_0FFC);
            fetch(addr);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sim.f
icache_cfg_pkg.sv
icache_ctrl_pkg.sv
icache_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
tb_icache.sv
